// ==== hw/alu_pkg.sv ====
package alu_pkg;

  localparam int DATA_W = 16;

  // width of the tag on the result bus, enough for an 8-slot reorder buffer
  localparam int TAG_W = 3;

  // SHL shifts by the low 4 bits of the second operand
  typedef enum logic [1:0] {
    ADD = 2'd0,
    SUB = 2'd1,
    XOR = 2'd2,
    SHL = 2'd3
  } alu_op_t;

  // one result per cycle, seen by the entries and the ROB
  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  cmt_id;
    logic [DATA_W-1:0] data;
  } result_bus_t;

endpackage

// ==== hw/sched_pkg.sv ====
package sched_pkg;

  // reorder slot number, also used as the wakeup tag
  typedef logic [alu_pkg::TAG_W-1:0] cmt_id_t;

  localparam int ROB_DEPTH = 2 ** $bits(cmt_id_t);

  typedef enum logic [1:0] {
    INIT          = 2'd0,
    WAIT          = 2'd1,
    ISSUED        = 2'd2,
    WAIT_COMPLETE = 2'd3
  } entry_state_t;

  typedef struct packed {
    logic [alu_pkg::DATA_W-$bits(cmt_id_t)-1:0] pad;
    cmt_id_t                                     id;
  } src2_tag_t;

  // second operand is either a producer tag or an immediate
  typedef union packed {
    src2_tag_t                  tag;
    logic [alu_pkg::DATA_W-1:0] imm;
  } src2_u;

  typedef struct packed {
    alu_pkg::alu_op_t           op;
    cmt_id_t                    cmt_id;
    cmt_id_t                    src1;
    src2_u                      src2;
    logic                       src2_is_imm;
    logic                       src1_ready;
    logic                       src2_ready;
    logic [alu_pkg::DATA_W-1:0] src1_val;
    logic [alu_pkg::DATA_W-1:0] src2_val;
  } disp_t;

endpackage

// ==== hw/sched_ifs.sv ====
`timescale 1ns/1ps

// dispatch handshake into the issue queue
interface disp_if;
  import sched_pkg::*;

  logic  valid;
  disp_t payload;
  logic  ready;

  modport producer (output valid, output payload, input ready);
  modport buffer (input valid, input payload, output ready);
endinterface

// picked instruction towards the ALU, no ready since the pipe never stalls
interface issue_if;
  import alu_pkg::*;
  import sched_pkg::*;

  logic              valid;
  alu_op_t           op;
  cmt_id_t           cmt_id;
  logic [DATA_W-1:0] src1_val;
  logic [DATA_W-1:0] src2_val;
  src2_u             src2;
  logic              src2_is_imm;

  modport buffer (
    output valid, output op, output cmt_id, output src1_val,
    output src2_val, output src2, output src2_is_imm
  );
  modport consumer (
    input valid, input op, input cmt_id, input src1_val,
    input src2_val, input src2, input src2_is_imm
  );
endinterface

// ==== hw/sched_entry.sv ====
`timescale 1ns/1ps

module sched_entry (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_put,
  input  sched_pkg::disp_t     i_put_data,
  input  alu_pkg::result_bus_t i_result,
  input  logic                 i_picked,
  input  logic                 i_retire_valid,
  input  sched_pkg::cmt_id_t   i_retire_id,
  output logic                 o_valid,
  output logic                 o_ready,
  output sched_pkg::disp_t     o_entry
);
  import sched_pkg::*;

  entry_state_t r_state;
  entry_state_t w_state_next;
  disp_t        r_entry;
  disp_t        w_base;
  disp_t        w_entry_next;
  logic         w_put;
  logic         w_load;
  logic         w_src1_hit;
  logic         w_src2_hit;
  logic         w_own_result;
  logic         w_own_retire;

  assign w_put  = i_put & (r_state == INIT);
  assign w_load = w_put | (r_state == WAIT);

  // on put, match the bus against the incoming tags
  assign w_base = w_put ? i_put_data : r_entry;

  assign w_src1_hit = i_result.valid & !w_base.src1_ready &
                      (i_result.cmt_id == w_base.src1);
  assign w_src2_hit = i_result.valid & !w_base.src2_ready & !w_base.src2_is_imm &
                      (i_result.cmt_id == w_base.src2.tag.id);

  always_comb begin
    w_entry_next = w_base;
    if (w_src1_hit) begin
      w_entry_next.src1_ready = 1'b1;
      w_entry_next.src1_val   = i_result.data;
    end
    if (w_src2_hit) begin
      w_entry_next.src2_ready = 1'b1;
      w_entry_next.src2_val   = i_result.data;
    end
  end

  assign w_own_result = i_result.valid & (i_result.cmt_id == r_entry.cmt_id);
  assign w_own_retire = i_retire_valid & (i_retire_id == r_entry.cmt_id);

  always_comb begin
    w_state_next = r_state;
    case (r_state)
      INIT: begin
        if (w_put) begin
          w_state_next = WAIT;
        end
      end
      WAIT: begin
        if (o_ready & i_picked) begin
          w_state_next = ISSUED;
        end
      end
      ISSUED: begin
        if (w_own_result) begin
          w_state_next = WAIT_COMPLETE;
        end
      end
      WAIT_COMPLETE: begin
        // hold the slot until the ROB retires it
        if (w_own_retire) begin
          w_state_next = INIT;
        end
      end
      default: begin
        w_state_next = INIT;
      end
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= INIT;
    end else begin
      r_state <= w_state_next;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_load) begin
      r_entry <= w_entry_next;
    end
  end

  assign o_valid = (r_state != INIT);
  // registered operands, so a capture in one cycle shows ready the next
  assign o_ready = (r_state == WAIT) & r_entry.src1_ready &
                   (r_entry.src2_ready | r_entry.src2_is_imm);
  assign o_entry = r_entry;

endmodule

// ==== hw/issue_queue.sv ====
`timescale 1ns/1ps

module issue_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  alu_pkg::result_bus_t i_result,
  input  logic                 i_retire_valid,
  input  sched_pkg::cmt_id_t   i_retire_id,
  disp_if.buffer               disp,
  issue_if.buffer              issue
);
  import sched_pkg::*;

  logic [QUEUE_DEPTH-1:0] w_valid;
  logic [QUEUE_DEPTH-1:0] w_ready;
  logic [QUEUE_DEPTH-1:0] w_free;
  logic [QUEUE_DEPTH-1:0] w_put_oh;
  logic [QUEUE_DEPTH-1:0] w_pick_oh;
  disp_t                  w_entries [QUEUE_DEPTH];
  disp_t                  w_sel;

  assign w_free = ~w_valid;

  // lowest set bit wins, for both allocation and pick
  assign w_put_oh  = w_free & (~w_free + 1'b1);
  assign w_pick_oh = w_ready & (~w_ready + 1'b1);

  assign disp.ready = |w_free;

  for (genvar i = 0; i < QUEUE_DEPTH; i++) begin : g_entry
    sched_entry entry_inst (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_put          (disp.valid & w_put_oh[i]),
      .i_put_data     (disp.payload),
      .i_result       (i_result),
      .i_picked       (w_pick_oh[i]),
      .i_retire_valid (i_retire_valid),
      .i_retire_id    (i_retire_id),
      .o_valid        (w_valid[i]),
      .o_ready        (w_ready[i]),
      .o_entry        (w_entries[i])
    );
  end

  always_comb begin
    w_sel = '0;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      if (w_pick_oh[i]) begin
        w_sel = w_entries[i];
      end
    end
  end

  // issue goes out in the pick cycle, the pipe registers it
  assign issue.valid       = |w_pick_oh;
  assign issue.op          = w_sel.op;
  assign issue.cmt_id      = w_sel.cmt_id;
  assign issue.src1_val    = w_sel.src1_val;
  assign issue.src2_val    = w_sel.src2_val;
  assign issue.src2        = w_sel.src2;
  assign issue.src2_is_imm = w_sel.src2_is_imm;

endmodule

// ==== hw/alu_pipe.sv ====
`timescale 1ns/1ps

module alu_pipe (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  issue_if.consumer            issue,
  output alu_pkg::result_bus_t o_result
);
  import alu_pkg::*;
  import sched_pkg::*;

  logic              r_s1_valid;
  alu_op_t           r_s1_op;
  cmt_id_t           r_s1_id;
  logic [DATA_W-1:0] r_s1_a;
  logic [DATA_W-1:0] r_s1_b;
  src2_u             r_s1_src2;
  logic              r_s1_is_imm;
  logic [DATA_W-1:0] w_b;
  logic [DATA_W-1:0] w_res;
  logic              r_res_valid;
  cmt_id_t           r_res_id;
  logic [DATA_W-1:0] r_res_data;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid  <= 1'b0;
      r_res_valid <= 1'b0;
    end else begin
      r_s1_valid  <= issue.valid;
      r_res_valid <= r_s1_valid;
    end
  end

  // stage 1
  always_ff @(posedge i_clk) begin
    if (issue.valid) begin
      r_s1_op     <= issue.op;
      r_s1_id     <= issue.cmt_id;
      r_s1_a      <= issue.src1_val;
      r_s1_b      <= issue.src2_val;
      r_s1_src2   <= issue.src2;
      r_s1_is_imm <= issue.src2_is_imm;
    end
  end

  // stage 2, immediate comes from the union's imm view
  assign w_b = r_s1_is_imm ? r_s1_src2.imm : r_s1_b;

  always_comb begin
    case (r_s1_op)
      ADD:     w_res = r_s1_a + w_b;
      SUB:     w_res = r_s1_a - w_b;
      XOR:     w_res = r_s1_a ^ w_b;
      SHL:     w_res = r_s1_a << w_b[3:0];
      default: w_res = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (r_s1_valid) begin
      r_res_id   <= r_s1_id;
      r_res_data <= w_res;
    end
  end

  assign o_result = '{valid: r_res_valid, cmt_id: r_res_id, data: r_res_data};

endmodule

// ==== hw/dispatch_rob.sv ====
`timescale 1ns/1ps

module dispatch_rob (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_disp_valid,
  input  alu_pkg::alu_op_t            i_disp_op,
  input  sched_pkg::cmt_id_t          i_disp_src1,
  input  sched_pkg::src2_u            i_disp_src2,
  input  logic                        i_disp_src2_is_imm,
  input  alu_pkg::result_bus_t        i_result,
  disp_if.producer                    disp,
  output logic                        o_disp_ready,
  output logic                        o_retire_valid,
  output sched_pkg::cmt_id_t          o_retire_id,
  output logic [alu_pkg::DATA_W-1:0]  o_retire_data
);
  import alu_pkg::*;
  import sched_pkg::*;

  cmt_id_t                    r_head;
  cmt_id_t                    r_tail;
  logic [$clog2(ROB_DEPTH):0] r_count;
  logic                       r_run;
  logic [ROB_DEPTH-1:0]       r_done;
  logic [ROB_DEPTH-1:0]       r_written;
  logic [DATA_W-1:0]          r_value [ROB_DEPTH];
  logic                       w_rob_free;
  logic                       w_alloc;
  logic                       w_retire;
  logic                       w_src1_hit;
  logic                       w_src2_hit;

  // r_run keeps dispatch closed while in reset
  assign w_rob_free   = r_run & (r_count != ROB_DEPTH);
  assign disp.valid   = i_disp_valid & w_rob_free;
  assign w_alloc      = disp.valid & disp.ready;
  assign o_disp_ready = w_rob_free & disp.ready;

  // source is ready if its slot holds a value or the value is on the bus now
  assign w_src1_hit = i_result.valid & (i_result.cmt_id == i_disp_src1);
  assign w_src2_hit = i_result.valid & (i_result.cmt_id == i_disp_src2.tag.id);

  always_comb begin
    disp.payload             = '0;
    disp.payload.op          = i_disp_op;
    disp.payload.cmt_id      = r_tail;
    disp.payload.src1        = i_disp_src1;
    disp.payload.src2        = i_disp_src2;
    disp.payload.src2_is_imm = i_disp_src2_is_imm;
    disp.payload.src1_ready  = r_written[i_disp_src1] | w_src1_hit;
    disp.payload.src1_val    = w_src1_hit ? i_result.data : r_value[i_disp_src1];
    if (!i_disp_src2_is_imm) begin
      disp.payload.src2_ready = r_written[i_disp_src2.tag.id] | w_src2_hit;
      disp.payload.src2_val   = w_src2_hit ? i_result.data : r_value[i_disp_src2.tag.id];
    end
  end

  // in-order retire, one per cycle
  assign w_retire       = r_done[r_head];
  assign o_retire_valid = w_retire;
  assign o_retire_id    = r_head;
  assign o_retire_data  = r_value[r_head];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_run     <= 1'b0;
      r_head    <= '0;
      r_tail    <= '0;
      r_count   <= '0;
      r_done    <= '0;
      r_written <= '1;
      for (int s = 0; s < ROB_DEPTH; s++) begin
        r_value[s] <= '0;
      end
    end else begin
      r_run <= 1'b1;
      if (i_result.valid) begin
        r_done[i_result.cmt_id]    <= 1'b1;
        r_written[i_result.cmt_id] <= 1'b1;
        r_value[i_result.cmt_id]   <= i_result.data;
      end
      if (w_alloc) begin
        r_written[r_tail] <= 1'b0;
        r_tail            <= r_tail + 1'b1;
      end
      if (w_retire) begin
        r_done[r_head] <= 1'b0;
        r_head         <= r_head + 1'b1;
      end
      r_count <= r_count + w_alloc - w_retire;
    end
  end

endmodule

// ==== hw/sched_top.sv ====
`timescale 1ns/1ps

module sched_top #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_disp_valid,
  input  alu_pkg::alu_op_t            i_disp_op,
  input  sched_pkg::cmt_id_t          i_disp_src1,
  input  sched_pkg::src2_u            i_disp_src2,
  input  logic                        i_disp_src2_is_imm,
  output logic                        o_disp_ready,
  output logic                        o_retire_valid,
  output sched_pkg::cmt_id_t          o_retire_id,
  output logic [alu_pkg::DATA_W-1:0]  o_retire_data
);
  import alu_pkg::*;

  result_bus_t w_result;

  disp_if  disp_bus ();
  issue_if issue_bus ();

  dispatch_rob dispatch_rob_inst (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_disp_valid       (i_disp_valid),
    .i_disp_op          (i_disp_op),
    .i_disp_src1        (i_disp_src1),
    .i_disp_src2        (i_disp_src2),
    .i_disp_src2_is_imm (i_disp_src2_is_imm),
    .i_result           (w_result),
    .disp               (disp_bus.producer),
    .o_disp_ready       (o_disp_ready),
    .o_retire_valid     (o_retire_valid),
    .o_retire_id        (o_retire_id),
    .o_retire_data      (o_retire_data)
  );

  // retire pulse also frees the matching queue entry
  issue_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) issue_queue_inst (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_result       (w_result),
    .i_retire_valid (o_retire_valid),
    .i_retire_id    (o_retire_id),
    .disp           (disp_bus.buffer),
    .issue          (issue_bus.buffer)
  );

  alu_pipe alu_pipe_inst (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .issue     (issue_bus.consumer),
    .o_result  (w_result)
  );

endmodule

// ==== tests/tb_sched_top.sv ====
`timescale 1ns/1ps

module tb_sched_top;
  import alu_pkg::*;
  import sched_pkg::*;

  localparam int N_RANDOM = 60;
  localparam int N_CHAIN  = 30;
  localparam int N_IMM    = 30;
  localparam int N_BURST  = 40;
  localparam int N_TOTAL  = N_RANDOM + N_CHAIN + N_IMM + N_BURST;
  // up to 20 cycles per instruction plus start-up margin
  localparam int WATCHDOG_CYCLES = N_TOTAL * 20 + 100;

  logic              i_clk;
  logic              i_reset_n;
  logic              i_disp_valid;
  alu_op_t           i_disp_op;
  cmt_id_t           i_disp_src1;
  src2_u             i_disp_src2;
  logic              i_disp_src2_is_imm;
  logic              o_disp_ready;
  logic              o_retire_valid;
  cmt_id_t           o_retire_id;
  logic [DATA_W-1:0] o_retire_data;

  integer            seed;
  int                errors;
  int                checks;
  int                n_sent;
  int                n_retired;
  int                stall_cycles;
  // model value held in each reorder slot
  logic [DATA_W-1:0] model_val [ROB_DEPTH];
  // expected retirements, oldest first
  cmt_id_t           exp_id [$];
  logic [DATA_W-1:0] exp_data [$];

  // queue as deep as the ROB so that a burst fills both
  sched_top #(
    .QUEUE_DEPTH (8)
  ) sched_top_inst (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_disp_valid       (i_disp_valid),
    .i_disp_op          (i_disp_op),
    .i_disp_src1        (i_disp_src1),
    .i_disp_src2        (i_disp_src2),
    .i_disp_src2_is_imm (i_disp_src2_is_imm),
    .o_disp_ready       (o_disp_ready),
    .o_retire_valid     (o_retire_valid),
    .o_retire_id        (o_retire_id),
    .o_retire_data      (o_retire_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
    end
  endtask

  function automatic logic [DATA_W-1:0] apply_op(input alu_op_t op,
                                                 input logic [DATA_W-1:0] a,
                                                 input logic [DATA_W-1:0] b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      XOR:     return a ^ b;
      default: return a << b[3:0];
    endcase
  endfunction

  task automatic choose_source(input int k, input int max_dist, output cmt_id_t slot);
    logic [31:0] r;
    int          d;
    r = $random(seed);
    if (k < ROB_DEPTH - 1 && (k == 0 || r[4])) begin
      // slot not allocated since reset still reads as zero
      slot = cmt_id_t'(k + 1 + int'(r[15:8]) % (ROB_DEPTH - 1 - k));
    end else begin
      d = 1 + int'(r[23:16]) % max_dist;
      if (d > k) begin
        d = k;
      end
      slot = cmt_id_t'((k - d) % ROB_DEPTH);
    end
  endtask

  task automatic send_instr(input int max_dist, input bit all_imm);
    logic [31:0]       r;
    alu_op_t           op;
    logic              is_imm;
    cmt_id_t           s1;
    cmt_id_t           s2;
    logic [DATA_W-1:0] word2;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] res;
    r = $random(seed);
    op = alu_op_t'(r[1:0]);
    is_imm = all_imm | (r[3:2] == 2'b00);
    choose_source(n_sent, max_dist, s1);
    choose_source(n_sent, max_dist, s2);
    // pad bits of the tag view are random and must not matter
    word2 = is_imm ? r[31:16] : {r[28:16], s2};
    b = is_imm ? word2 : model_val[s2];
    res = apply_op(op, model_val[s1], b);
    model_val[n_sent % ROB_DEPTH] = res;
    exp_id.push_back(cmt_id_t'(n_sent % ROB_DEPTH));
    exp_data.push_back(res);
    @(negedge i_clk);
    i_disp_valid       = 1'b1;
    i_disp_op          = op;
    i_disp_src1        = s1;
    i_disp_src2        = word2;
    i_disp_src2_is_imm = is_imm;
    // hold until accepted at the coming rising edge
    while (!o_disp_ready) begin
      stall_cycles++;
      @(negedge i_clk);
    end
    n_sent++;
  endtask

  task automatic idle_cycle();
    @(negedge i_clk);
    i_disp_valid = 1'b0;
  endtask

  task automatic drain();
    idle_cycle();
    while (exp_id.size() != 0) begin
      @(negedge i_clk);
    end
  endtask

  // retire checker
  always @(negedge i_clk) begin
    if (i_reset_n && o_retire_valid) begin
      n_retired++;
      if (exp_id.size() == 0) begin
        errors++;
        $display("slot %0d retired at %0t ns with no instruction outstanding",
                 o_retire_id, $time);
      end else begin
        check_value("retire id", 32'(o_retire_id), 32'(exp_id.pop_front()));
        check_value("retire data", 32'(o_retire_data), 32'(exp_data.pop_front()));
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    seed               = 32'hce78_07bb;
    errors             = 0;
    checks             = 0;
    n_sent             = 0;
    n_retired          = 0;
    stall_cycles       = 0;
    i_reset_n          = 1'b0;
    i_disp_valid       = 1'b0;
    i_disp_op          = ADD;
    i_disp_src1        = '0;
    i_disp_src2        = '0;
    i_disp_src2_is_imm = 1'b0;
    for (int s = 0; s < ROB_DEPTH; s++) begin
      model_val[s] = '0;
    end

    repeat (2) begin
      @(negedge i_clk);
      check_value("disp ready in reset", 32'(o_disp_ready), 32'd0);
      check_value("retire valid in reset", 32'(o_retire_valid), 32'd0);
    end
    i_reset_n = 1'b1;
    repeat (6) begin
      @(negedge i_clk);
      check_value("retire valid before first dispatch", 32'(o_retire_valid), 32'd0);
    end

    // mixed program with random gaps
    for (int i = 0; i < N_RANDOM; i++) begin
      if (($random(seed) & 3) == 0) begin
        idle_cycle();
      end
      send_instr(3, 1'b0);
    end
    drain();

    // each link of the chain dispatches while its source result is on the bus
    for (int i = 0; i < N_CHAIN; i++) begin
      send_instr(1, 1'b0);
      idle_cycle();
      idle_cycle();
    end
    drain();

    for (int i = 0; i < N_IMM; i++) begin
      send_instr(3, 1'b1);
    end
    drain();

    // long back-to-back chain that fills the queue and the ROB
    stall_cycles = 0;
    for (int i = 0; i < N_BURST; i++) begin
      send_instr(1, 1'b0);
    end
    drain();
    if (stall_cycles == 0) begin
      errors++;
      $display("dispatch was never held back during the burst");
    end

    repeat (10) @(negedge i_clk);
    check_value("number of retirements", 32'(n_retired), 32'(n_sent));
    $display("dispatched %0d, retired %0d, checks %0d, errors %0d",
             n_sent, n_retired, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/alu_pkg.sv
hw/sched_pkg.sv
hw/sched_ifs.sv
hw/sched_entry.sv
hw/issue_queue.sv
hw/alu_pipe.sv
hw/dispatch_rob.sv
hw/sched_top.sv
tests/tb_sched_top.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_sched_top -o sim

run: compile
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
